// File: bench/packet_host_vectors.txt
# Columns, hex: rst valid dest_addr out_hold packet_in drop
# One line per clock cycle; drop marks a strobe the full buffer must reject
test single
0 1 3 0 0123456789abcdef 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 1 a 0 fedcba9876543210 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
test burst
0 1 1 0 1111111111111111 0
0 1 2 0 2222222222222222 0
0 1 4 0 3333333333333333 0
0 1 8 0 4444444444444444 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
test overflow
0 0 0 1 0 0
0 1 5 1 a0a0a0a0a0a0a0a0 0
0 1 6 1 b1b1b1b1b1b1b1b1 0
0 1 7 1 c2c2c2c2c2c2c2c2 0
0 1 9 1 d3d3d3d3d3d3d3d3 0
0 1 f 1 e4e4e4e4e4e4e4e4 1
0 0 0 1 0 0
test release
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
test midreset
0 0 0 1 0 0
0 1 2 1 5555555555555555 0
0 1 3 1 6666666666666666 0
1 0 0 0 0 0
1 0 0 0 0 0
0 1 c 0 7777777777777777 0

// File: packet_host.f
hw/packet_host_pkg.sv
hw/packet_fifo.sv
hw/keystream_gen.sv
hw/route_ctrl.sv
hw/packet_host_top.sv
bench/packet_host_asserts.sv
bench/packet_host_tb.sv

// File: Bender.yml
package:
  name: packet_host

sources:
  - hw/packet_host_pkg.sv
  - hw/packet_fifo.sv
  - hw/keystream_gen.sv
  - hw/route_ctrl.sv
  - hw/packet_host_top.sv
  - target: test
    files:
      - bench/packet_host_asserts.sv
      - bench/packet_host_tb.sv

// File: bench/packet_host_tb.sv
/* Packet host testbench
   Replays cycle vectors, models the key schedule and buffer, checks every output */
`default_nettype none

module packet_host_tb;

    import packet_host_pkg::*;

    localparam int max_lines   = 200;
    localparam int drain_limit = 60;

    logic                 clk;
    logic                 rst;
    packet_t              packet_in;
    logic                 packet_valid;
    logic [addr_bits-1:0] dest_addr;
    logic                 out_hold;
    packet_t              packet_out;
    logic                 packet_ready;
    logic                 route_error;

    // Reference model state
    logic [2*packet_bits-1:0] model_key;
    packet_t                  exp_q [$];       // Accepted and not yet sent
    string                    name_q [$];
    int                       buf_cnt;
    int                       phase;           // 0 idle, 1 process, 2 send
    logic                     err_exp;
    logic                     err_file;
    logic                     drop_applied;
    packet_t                  exp_out;
    string                    exp_name;
    string                    cur_test;
    string                    test_applied;
    int                       fd;
    int                       lines;
    int                       cycles;

    packet_host_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .packet_in    (packet_in),
        .packet_valid (packet_valid),
        .dest_addr    (dest_addr),
        .out_hold     (out_hold),
        .packet_out   (packet_out),
        .packet_ready (packet_ready),
        .route_error  (route_error)
    );

    always #20 clk = ~clk;

    // Mask is the upper key half XOR the lower half
    function automatic packet_t key_fold(input logic [2*packet_bits-1:0] key);
        return key[2*packet_bits-1:packet_bits] ^ key[packet_bits-1:0];
    endfunction

    // Rotate left by the address width, then mix the destination into the wrapped bits
    function automatic logic [2*packet_bits-1:0] key_rotate(
        input logic [2*packet_bits-1:0] key,
        input logic [addr_bits-1:0]     addr
    );
        logic [2*packet_bits-1:0] rot;
        rot = (key << addr_bits) | (key >> (2*packet_bits - addr_bits));
        rot[addr_bits-1:0] = rot[addr_bits-1:0] ^ addr;
        return rot;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input packet_t expected, input packet_t actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic model_reset;
        model_key = key_init;
        exp_q.delete();
        name_q.delete();
        buf_cnt  = 0;
        phase    = 0;
        err_exp  = 1'b0;
        err_file = 1'b0;
        exp_out  = '0;
        exp_name = "reset";
    endtask

    // One clock edge of the reference model on the inputs the DUT samples
    task automatic model_step;
        logic full;
        logic do_pop;
        if (rst) begin
            model_reset();
        end else begin
            full     = (buf_cnt == buffer_depth);
            do_pop   = (phase == 0) && (buf_cnt > 0) && !out_hold;
            err_exp  = packet_valid && full;
            err_file = drop_applied;
            if (packet_valid && !full) begin
                exp_q.push_back(packet_in ^ key_fold(model_key));
                name_q.push_back(test_applied);
                buf_cnt++;
            end
            if (do_pop) begin
                buf_cnt--;
            end
            case (phase)
                0: phase = do_pop ? 1 : 0;
                1: phase = 2;
                default: phase = 0;
            endcase
            if (packet_valid) begin
                model_key = key_rotate(model_key, dest_addr);  // Dropped strobes too
            end
        end
    endtask

    task automatic check_outputs;
        logic exp_ready;
        exp_ready = (phase == 2);
        check_value({test_applied, " packet_ready"}, packet_t'(exp_ready),
                    packet_t'(packet_ready));
        if (exp_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("packet_ready seen while the model holds no packet");
            end else begin
                exp_out  = exp_q.pop_front();
                exp_name = name_q.pop_front();
            end
        end
        check_value({exp_name, " packet_out"}, exp_out, packet_out);
        check_value({test_applied, " route_error"}, packet_t'(err_exp),
                    packet_t'(route_error));
        check_value({test_applied, " route_error from vectors"}, packet_t'(err_file),
                    packet_t'(route_error));
    endtask

    // Drive one vector on the rising edge and check outputs on the falling edge
    task automatic run_cycle(
        input logic                 r,
        input logic                 v,
        input logic [addr_bits-1:0] d,
        input logic                 h,
        input packet_t              p,
        input logic                 drop
    );
        @(posedge clk);
        model_step();
        rst          <= r;
        packet_valid <= v;
        dest_addr    <= d;
        out_hold     <= h;
        packet_in    <= p;
        drop_applied = drop;
        test_applied = cur_test;
        if (r) begin
            model_reset();   // Async reset acts right after this edge
        end
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        string                line;
        logic                 r;
        logic                 v;
        logic [addr_bits-1:0] d;
        logic                 h;
        packet_t              p;
        logic                 drop;
        int                   n;
        clk          = 1'b0;
        rst          = 1'b0;
        packet_in    = '0;
        packet_valid = 1'b0;
        dest_addr    = '0;
        out_hold     = 1'b0;
        drop_applied = 1'b0;
        cur_test     = "reset";
        test_applied = "reset";
        model_reset();
        fd = $fopen("bench/packet_host_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open bench/packet_host_vectors.txt");
        end
        @(posedge clk);
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        lines = 0;
        while (!$feof(fd) && lines < max_lines) begin
            n = $fgets(line, fd);
            lines++;
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                if (line.substr(0, 3) == "test") begin
                    n = $sscanf(line, "test %s", cur_test);
                end else begin
                    n = $sscanf(line, "%h %h %h %h %h %h", r, v, d, h, p, drop);
                    if (n != 6) begin
                        abort_run({"malformed vector line: ", line});
                    end
                    run_cycle(r, v, d, h, p, drop);
                end
            end
        end
        $fclose(fd);
        // Let everything still buffered go out
        cur_test = "drain";
        cycles   = 0;
        while ((exp_q.size() != 0 || phase != 0) && cycles < drain_limit) begin
            run_cycle(1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
            cycles++;
        end
        if (exp_q.size() == 0 && phase == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("drain timed out, %0d packets never came out", exp_q.size());
            $display("sim failed");
            $fatal(1, "drain timeout");
        end
    end

endmodule

`default_nettype wire

// File: bench/packet_host_asserts.sv
/* Packet host assertions
   Ready pulse shape, overflow flag cause and output values in reset */
`default_nettype none

module packet_host_asserts (
    input logic                     clk,
    input logic                     rst,
    input logic                     packet_valid,
    input logic                     full,
    input packet_host_pkg::packet_t packet_out,
    input logic                     packet_ready,
    input logic                     route_error
);

    // Ready never lasts more than one cycle
    ready_single_pulse: assert property (
        @(posedge clk) disable iff (rst) packet_ready |=> !packet_ready
    ) else $error("packet_ready high in two consecutive cycles");

    // Overflow flag follows a strobe into a full buffer
    error_has_cause: assert property (
        @(posedge clk) disable iff (rst) route_error |-> $past(packet_valid && full)
    ) else $error("route_error without a valid strobe on a full buffer");

    reset_outputs_low: assert property (
        @(posedge clk) rst |-> (!packet_ready && !route_error)
    ) else $error("packet_ready or route_error high during reset");

    reset_data_clear: assert property (
        @(posedge clk) rst |-> (packet_out == '0)
    ) else $error("packet_out not cleared during reset");

endmodule

bind packet_host_top packet_host_asserts u_asserts (
    .clk          (clk),
    .rst          (rst),
    .packet_valid (packet_valid),
    .full         (full),
    .packet_out   (packet_out),
    .packet_ready (packet_ready),
    .route_error  (route_error)
);

`default_nettype wire

// File: hw/packet_host_top.sv
/* Packet host top level
   Key schedule, four-entry buffer and send control, with overflow flag */
`default_nettype none

module packet_host_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  packet_host_pkg::packet_t             packet_in,
    input  logic                                 packet_valid,
    input  logic [packet_host_pkg::addr_bits-1:0] dest_addr,
    input  logic                                 out_hold,
    output packet_host_pkg::packet_t             packet_out,
    output logic                                 packet_ready,
    output logic                                 route_error
);

    import packet_host_pkg::*;

    packet_t       mask;
    packet_entry_t push_entry;
    packet_entry_t head_entry;
    logic          push;
    logic          pop;
    logic          full;
    logic          empty;

    keystream_gen u_keys (
        .clk          (clk),
        .rst          (rst),
        .packet_valid (packet_valid),
        .dest_addr    (dest_addr),
        .mask         (mask)
    );

    // Accept only with room left, mask sampled at the same edge
    assign push       = packet_valid && !full;
    assign push_entry = '{data: packet_in, mask: mask};

    packet_fifo #(
        .payload_t (packet_entry_t),
        .depth     (buffer_depth)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_entry),
        .pop       (pop),
        .pop_data  (head_entry),
        .full      (full),
        .empty     (empty)
    );

    route_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .empty        (empty),
        .out_hold     (out_hold),
        .head         (head_entry),
        .pop          (pop),
        .packet_out   (packet_out),
        .packet_ready (packet_ready)
    );

    // Dropped packet flagged for the following cycle only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            route_error <= 1'b0;
        end else begin
            route_error <= packet_valid && full;
        end
    end

endmodule

`default_nettype wire

// File: hw/route_ctrl.sv
/* Send control
   Pops one buffer entry, scrambles it with its mask and pulses packet_ready */
`default_nettype none

module route_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          empty,
    input  logic                          out_hold,
    input  packet_host_pkg::packet_entry_t head,
    output logic                          pop,
    output packet_host_pkg::packet_t      packet_out,
    output logic                          packet_ready
);

    import packet_host_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_process,
        st_send
    } state_t;

    state_t        state_q;
    packet_entry_t entry_q;

    // Hold only blocks a new pop, an entry in flight still goes out
    assign pop = (state_q == st_idle) && !empty && !out_hold;

    // One cycle per packet, decoded from the state register
    assign packet_ready = (state_q == st_send);

    // Entry taken from the head on the pop edge
    always_ff @(posedge clk) begin
        if (pop) begin
            entry_q <= head;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= st_idle;
            packet_out <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (pop) begin
                        state_q <= st_process;
                    end
                end
                st_process: begin
                    packet_out <= entry_q.data ^ entry_q.mask;  // Scramble
                    state_q    <= st_send;
                end
                st_send: begin
                    state_q <= st_idle;
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/keystream_gen.sv
/* Network key schedule
   Rotates the key on every valid strobe, mixes in dest_addr, folds out the mask */
`default_nettype none

module keystream_gen (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 packet_valid,
    input  logic [packet_host_pkg::addr_bits-1:0] dest_addr,
    output packet_host_pkg::packet_t             mask
);

    import packet_host_pkg::*;

    logic [2*packet_bits-1:0] key_q;
    logic [2*packet_bits-1:0] key_next;

    // Rotate left by addr_bits, wrapped bits XORed with the destination
    assign key_next = {key_q[2*packet_bits-addr_bits-1:0],
                       key_q[2*packet_bits-1 -: addr_bits] ^ dest_addr};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_q <= key_init;
        end else if (packet_valid) begin
            key_q <= key_next;          // Rejected packets advance it too
        end
    end

    // Fold of the current key, before this edge's update
    assign mask = key_q[2*packet_bits-1 -: packet_bits] ^ key_q[packet_bits-1:0];

endmodule

`default_nettype wire

// File: hw/packet_fifo.sv
/* Circular packet buffer
   Generic payload with head/tail pointers, occupancy count, full and empty flags */
`default_nettype none

module packet_fifo #(
    parameter type payload_t = logic [63:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_bits = $clog2(depth + 1);

    payload_t            mem [depth];
    logic [ptr_bits-1:0] head_q;
    logic [ptr_bits-1:0] tail_q;
    logic [cnt_bits-1:0] count_q;
    logic                do_push;
    logic                do_pop;

    // Wrap at depth, not at the power of two
    function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
        logic [ptr_bits-1:0] nxt;
        if (ptr == ptr_bits'(depth - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign full  = (count_q == cnt_bits'(depth));
    assign empty = (count_q == '0);

    // Overflow and underflow requests are dropped here
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign pop_data = mem[head_q];      // Head entry visible before the pop

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[tail_q] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                tail_q <= next_ptr(tail_q);
            end
            if (do_pop) begin
                head_q <= next_ptr(head_q);
            end
            // Simultaneous push and pop keeps the count
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/packet_host_pkg.sv
/* Packet host shared definitions
   Packet and address sizes, network key seed and buffer entry layout */
`default_nettype none

package packet_host_pkg;

    // Packet word width
    localparam int packet_bits = 64;

    // Number of buffered packets
    localparam int buffer_depth = 4;

    localparam int addr_bits = 4;        // Width of dest_addr

    // Network key seed, loaded on reset
    localparam logic [2*packet_bits-1:0] key_init =
        128'h1234_5678_9ABC_DEF0_FEDC_BA09_8765_4321;

    // One packet word
    typedef logic [packet_bits-1:0] packet_t;

    // Buffer entry, raw packet plus the mask captured at accept time
    typedef struct packed {
        packet_t data;
        packet_t mask;                   // Key fold at acceptance
    } packet_entry_t;

endpackage

`default_nettype wire
